/* pipe_settings.svh */
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Datapath and register file dimensions
`define PIPE_DATA_W     32
`define PIPE_REG_COUNT  8
`define PIPE_INSTR_W    32
`define PIPE_IMM_W      16

// Instruction field positions around the unused bit 16
`define PIPE_OP_HI      31
`define PIPE_OP_LO      29
`define PIPE_SIZE_HI    28
`define PIPE_SIZE_LO    27
`define PIPE_DR_HI      26
`define PIPE_DR_LO      24
`define PIPE_SR1_HI     23
`define PIPE_SR1_LO     21
`define PIPE_SR2_HI     20
`define PIPE_SR2_LO     18
`define PIPE_IMM_FLAG   17
`define PIPE_IMM_HI     15
`define PIPE_IMM_LO     0

`endif

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

`include "pipe_settings.svh"

   typedef logic [`PIPE_DATA_W-1:0] word_t;
   typedef logic [`PIPE_INSTR_W-1:0] instr_t;
   typedef logic [$clog2(`PIPE_REG_COUNT)-1:0] reg_id_t;
   typedef logic [`PIPE_IMM_W-1:0] imm_t;

   // Zero, sign, carry from the top bit down
   typedef logic [2:0] flags_t;

   typedef enum logic [2:0] {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_and = 3'd2,
      op_or  = 3'd3,
      op_xor = 3'd4,
      op_mov = 3'd5,
      op_not = 3'd6,
      op_shl = 3'd7
   } alu_op_e;

   // Code 3 is folded into size_32 by decode
   typedef enum logic [1:0] {
      size_8  = 2'd0,
      size_16 = 2'd1,
      size_32 = 2'd2
   } data_size_e;

endpackage

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module decode_stage (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  ir_valid,
   input  wire pipe_pkg::instr_t ir,
   output logic                 de_valid,
   output pipe_pkg::alu_op_e    de_op,
   output pipe_pkg::data_size_e de_size,
   output pipe_pkg::reg_id_t    de_dr,
   output pipe_pkg::reg_id_t    de_sr1,
   output pipe_pkg::reg_id_t    de_sr2,
   output pipe_pkg::word_t      de_src2,
   output logic                 de_use_imm
);

   import pipe_pkg::*;

   logic   valid_q;
   instr_t ir_q;
   imm_t   imm;

   // Valid strobe for the latched word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= ir_valid;
      end
   end

   // Instruction word, loaded every cycle
   always_ff @(posedge clk) begin
      ir_q <= ir;
   end

   assign de_valid = valid_q;

   // Field extraction from the latched word
   assign de_op      = alu_op_e'(ir_q[`PIPE_OP_HI:`PIPE_OP_LO]);
   assign de_dr      = ir_q[`PIPE_DR_HI:`PIPE_DR_LO];
   assign de_sr1     = ir_q[`PIPE_SR1_HI:`PIPE_SR1_LO];
   assign de_sr2     = ir_q[`PIPE_SR2_HI:`PIPE_SR2_LO];
   assign de_use_imm = ir_q[`PIPE_IMM_FLAG];

   always_comb begin
      case (ir_q[`PIPE_SIZE_HI:`PIPE_SIZE_LO])
         2'd0: begin
            de_size = size_8;
         end
         2'd1: begin
            de_size = size_16;
         end
         default: begin
            // Unused code behaves as a full word
            de_size = size_32;
         end
      endcase
   end

   // Sign-extend the immediate to a full word
   assign imm     = ir_q[`PIPE_IMM_HI:`PIPE_IMM_LO];
   assign de_src2 = {{(`PIPE_DATA_W - `PIPE_IMM_W){imm[`PIPE_IMM_W-1]}}, imm};

endmodule

`default_nettype wire

/* operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       de_valid,
   input  wire pipe_pkg::alu_op_e    de_op,
   input  wire pipe_pkg::data_size_e de_size,
   input  wire pipe_pkg::reg_id_t    de_dr,
   input  wire pipe_pkg::reg_id_t    de_sr1,
   input  wire pipe_pkg::reg_id_t    de_sr2,
   input  wire pipe_pkg::word_t      de_src2,
   input  wire                       de_use_imm,
   input  wire pipe_pkg::word_t      rd_data1,
   input  wire pipe_pkg::word_t      rd_data2,
   input  wire pipe_pkg::word_t      rd_data3,
   input  wire                       fwd_valid,
   input  wire pipe_pkg::reg_id_t    fwd_dr,
   input  wire pipe_pkg::word_t      fwd_data,
   output pipe_pkg::reg_id_t         rd_id1,
   output pipe_pkg::reg_id_t         rd_id2,
   output pipe_pkg::reg_id_t         rd_id3,
   output logic                      ex_valid,
   output pipe_pkg::alu_op_e         ex_op,
   output pipe_pkg::data_size_e      ex_size,
   output pipe_pkg::reg_id_t         ex_dr,
   output pipe_pkg::word_t           ex_a,
   output pipe_pkg::word_t           ex_b,
   output pipe_pkg::word_t           ex_d_old
);

   import pipe_pkg::*;

   word_t src1_val;
   word_t src2_val;
   word_t dst_val;
   word_t opnd_b;

   // Register file lookups for both sources and the destination
   assign rd_id1 = de_sr1;
   assign rd_id2 = de_sr2;
   assign rd_id3 = de_dr;

   // The instruction in execute has not written yet, so take its result
   assign src1_val = (fwd_valid && fwd_dr == de_sr1) ? fwd_data : rd_data1;
   assign src2_val = (fwd_valid && fwd_dr == de_sr2) ? fwd_data : rd_data2;
   assign dst_val  = (fwd_valid && fwd_dr == de_dr)  ? fwd_data : rd_data3;

   // Immediate or register for operand 2
   assign opnd_b = de_use_imm ? de_src2 : src2_val;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= de_valid;
      end
   end

   // Operands and control fields for execute
   always_ff @(posedge clk) begin
      ex_op    <= de_op;
      ex_size  <= de_size;
      ex_dr    <= de_dr;
      ex_a     <= src1_val;
      ex_b     <= opnd_b;
      ex_d_old <= dst_val;
   end

endmodule

`default_nettype wire

/* gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module gpr_file (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire pipe_pkg::reg_id_t rd_id1,
   input  wire pipe_pkg::reg_id_t rd_id2,
   input  wire pipe_pkg::reg_id_t rd_id3,
   output pipe_pkg::word_t        rd_data1,
   output pipe_pkg::word_t        rd_data2,
   output pipe_pkg::word_t        rd_data3,
   input  wire                    wr_en,
   input  wire pipe_pkg::reg_id_t wr_id,
   input  wire pipe_pkg::word_t   wr_data
);

   import pipe_pkg::*;

   word_t regs [`PIPE_REG_COUNT];

   // Registers clear on reset and take one write per cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wr_en) begin
         regs[wr_id] <= wr_data;
      end
   end

   // Asynchronous read ports
   assign rd_data1 = regs[rd_id1];
   assign rd_data2 = regs[rd_id2];
   assign rd_data3 = regs[rd_id3];

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module execute_stage (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       ex_valid,
   input  wire pipe_pkg::alu_op_e    ex_op,
   input  wire pipe_pkg::data_size_e ex_size,
   input  wire pipe_pkg::reg_id_t    ex_dr,
   input  wire pipe_pkg::word_t      ex_a,
   input  wire pipe_pkg::word_t      ex_b,
   input  wire pipe_pkg::word_t      ex_d_old,
   output logic                      fwd_valid,
   output pipe_pkg::reg_id_t         fwd_dr,
   output pipe_pkg::word_t           fwd_data,
   output logic                      wr_en,
   output pipe_pkg::reg_id_t         wr_id,
   output pipe_pkg::word_t           wr_data,
   output logic                      wb_valid,
   output pipe_pkg::reg_id_t         wb_dr,
   output pipe_pkg::word_t           wb_data,
   output pipe_pkg::flags_t          flags
);

   import pipe_pkg::*;

   word_t                size_mask;
   word_t                a_m;
   word_t                b_m;
   logic [`PIPE_DATA_W:0] raw;
   word_t                res;
   word_t                merged;
   logic                 carry_out;
   logic                 sign_bit;
   logic                 carry_op;
   flags_t               flags_next;

   always_comb begin
      case (ex_size)
         size_8: begin
            size_mask = word_t'(8'hff);
         end
         size_16: begin
            size_mask = word_t'(16'hffff);
         end
         default: begin
            size_mask = '1;
         end
      endcase
   end

   assign a_m = ex_a & size_mask;
   assign b_m = ex_b & size_mask;

   // One extra bit on top catches carry, borrow and shifted-out bits
   always_comb begin
      case (ex_op)
         op_add:  raw = {1'b0, a_m} + {1'b0, b_m};
         op_sub:  raw = {1'b0, a_m} - {1'b0, b_m};
         op_and:  raw = {1'b0, a_m & b_m};
         op_or:   raw = {1'b0, a_m | b_m};
         op_xor:  raw = {1'b0, a_m ^ b_m};
         op_mov:  raw = {1'b0, b_m};
         op_not:  raw = {1'b0, ~a_m};
         op_shl:  raw = {1'b0, a_m} << b_m[4:0];
         default: raw = '0;
      endcase
   end

   assign res = raw[`PIPE_DATA_W-1:0] & size_mask;

   // Carry and sign sit just above and at the top of the operand size
   always_comb begin
      case (ex_size)
         size_8: begin
            carry_out = raw[8];
            sign_bit  = res[7];
         end
         size_16: begin
            carry_out = raw[16];
            sign_bit  = res[15];
         end
         default: begin
            carry_out = raw[`PIPE_DATA_W];
            sign_bit  = res[`PIPE_DATA_W-1];
         end
      endcase
   end

   assign carry_op   = (ex_op == op_add) || (ex_op == op_sub) || (ex_op == op_shl);
   assign flags_next = {res == '0, sign_bit, carry_op & carry_out};

   // Upper bits of the destination survive a narrow write
   assign merged = (ex_d_old & ~size_mask) | res;

   assign fwd_valid = ex_valid;
   assign fwd_dr    = ex_dr;
   assign fwd_data  = merged;

   assign wr_en   = ex_valid;
   assign wr_id   = ex_dr;
   assign wr_data = merged;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         flags    <= '0;
      end else begin
         wb_valid <= ex_valid;
         // mov leaves the flags alone
         if (ex_valid && ex_op != op_mov) begin
            flags <= flags_next;
         end
      end
   end

   always_ff @(posedge clk) begin
      wb_dr   <= ex_dr;
      wb_data <= merged;
   end

endmodule

`default_nettype wire

/* pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_top (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    ir_valid,
   input  wire pipe_pkg::instr_t  ir,
   output logic                   wb_valid,
   output pipe_pkg::reg_id_t      wb_dr,
   output pipe_pkg::word_t        wb_data,
   output pipe_pkg::flags_t       flags
);

   import pipe_pkg::*;

   // Decode to operand latch
   logic       de_valid;
   alu_op_e    de_op;
   data_size_e de_size;
   reg_id_t    de_dr;
   reg_id_t    de_sr1;
   reg_id_t    de_sr2;
   word_t      de_src2;
   logic       de_use_imm;

   // Register file read ports
   reg_id_t rd_id1;
   reg_id_t rd_id2;
   reg_id_t rd_id3;
   word_t   rd_data1;
   word_t   rd_data2;
   word_t   rd_data3;

   // Operand latch to execute
   logic       ex_valid;
   alu_op_e    ex_op;
   data_size_e ex_size;
   reg_id_t    ex_dr;
   word_t      ex_a;
   word_t      ex_b;
   word_t      ex_d_old;

   // Execute back to operands and the register file
   logic    fwd_valid;
   reg_id_t fwd_dr;
   word_t   fwd_data;
   logic    wr_en;
   reg_id_t wr_id;
   word_t   wr_data;

   decode_stage i_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .ir_valid   (ir_valid),
      .ir         (ir),
      .de_valid   (de_valid),
      .de_op      (de_op),
      .de_size    (de_size),
      .de_dr      (de_dr),
      .de_sr1     (de_sr1),
      .de_sr2     (de_sr2),
      .de_src2    (de_src2),
      .de_use_imm (de_use_imm)
   );

   operand_stage i_operand (
      .clk        (clk),
      .rst_n      (rst_n),
      .de_valid   (de_valid),
      .de_op      (de_op),
      .de_size    (de_size),
      .de_dr      (de_dr),
      .de_sr1     (de_sr1),
      .de_sr2     (de_sr2),
      .de_src2    (de_src2),
      .de_use_imm (de_use_imm),
      .rd_data1   (rd_data1),
      .rd_data2   (rd_data2),
      .rd_data3   (rd_data3),
      .fwd_valid  (fwd_valid),
      .fwd_dr     (fwd_dr),
      .fwd_data   (fwd_data),
      .rd_id1     (rd_id1),
      .rd_id2     (rd_id2),
      .rd_id3     (rd_id3),
      .ex_valid   (ex_valid),
      .ex_op      (ex_op),
      .ex_size    (ex_size),
      .ex_dr      (ex_dr),
      .ex_a       (ex_a),
      .ex_b       (ex_b),
      .ex_d_old   (ex_d_old)
   );

   gpr_file i_gpr (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_id1   (rd_id1),
      .rd_id2   (rd_id2),
      .rd_id3   (rd_id3),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .rd_data3 (rd_data3),
      .wr_en    (wr_en),
      .wr_id    (wr_id),
      .wr_data  (wr_data)
   );

   execute_stage i_execute (
      .clk       (clk),
      .rst_n     (rst_n),
      .ex_valid  (ex_valid),
      .ex_op     (ex_op),
      .ex_size   (ex_size),
      .ex_dr     (ex_dr),
      .ex_a      (ex_a),
      .ex_b      (ex_b),
      .ex_d_old  (ex_d_old),
      .fwd_valid (fwd_valid),
      .fwd_dr    (fwd_dr),
      .fwd_data  (fwd_data),
      .wr_en     (wr_en),
      .wr_id     (wr_id),
      .wr_data   (wr_data),
      .wb_valid  (wb_valid),
      .wb_dr     (wb_dr),
      .wb_data   (wb_data),
      .flags     (flags)
   );

endmodule

`default_nettype wire

/* pipeline_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_properties (
   input wire                   clk,
   input wire                   rst_n,
   input wire                   ir_valid,
   input wire                   wb_valid,
   input wire pipe_pkg::flags_t flags
);

   // Writeback is idle right after a reset cycle
   wb_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid)
      else $error("wb_valid high in the cycle after reset");

   // Three stages between the host strobe and writeback
   wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid == $past(ir_valid, 3))
      else $error("wb_valid does not follow ir_valid by three cycles");

   flags_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(rst_n) && !wb_valid) |-> $stable(flags))
      else $error("flags changed without a writeback");

endmodule

bind pipeline_top pipeline_properties i_props (
   .clk      (clk),
   .rst_n    (rst_n),
   .ir_valid (ir_valid),
   .wb_valid (wb_valid),
   .flags    (flags)
);

`default_nettype wire

/* tb_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module tb_pipeline;

   import pipe_pkg::*;

   localparam int N_ROWS   = 17;
   localparam int N_RAND   = 200;
   localparam int PERIOD   = 40;
   localparam int TIMEOUT  = (N_ROWS + N_RAND + 20) * PERIOD;

   logic    clk;
   logic    rst_n;
   logic    ir_valid;
   instr_t  ir;
   logic    wb_valid;
   reg_id_t wb_dr;
   word_t   wb_data;
   flags_t  flags;

   // Stimulus table
   logic    tbl_valid [N_ROWS];
   instr_t  tbl_ir    [N_ROWS];
   reg_id_t tbl_dr    [N_ROWS];
   word_t   tbl_data  [N_ROWS];
   flags_t  tbl_flags [N_ROWS];

   // Sequential reference model state
   word_t   model_regs [8];
   flags_t  model_flags;

   logic [31:0] lfsr;
   logic [2:0]  exp_dr_q    [$];
   word_t       exp_data_q  [$];
   flags_t      exp_flags_q [$];
   int          errors;
   int          sent_count;
   int          wb_count;

   pipeline_top i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .ir_valid (ir_valid),
      .ir       (ir),
      .wb_valid (wb_valid),
      .wb_dr    (wb_dr),
      .wb_data  (wb_data),
      .flags    (flags)
   );

   always #(PERIOD / 2) clk = ~clk;

   function automatic instr_t encode(input logic [2:0] op, input logic [1:0] sz,
                                     input logic [2:0] dr, input logic [2:0] sr1,
                                     input logic [2:0] sr2, input logic use_imm,
                                     input logic [15:0] imm);
      instr_t w;
      w = '0;
      w[`PIPE_OP_HI:`PIPE_OP_LO]     = op;
      w[`PIPE_SIZE_HI:`PIPE_SIZE_LO] = sz;
      w[`PIPE_DR_HI:`PIPE_DR_LO]     = dr;
      w[`PIPE_SR1_HI:`PIPE_SR1_LO]   = sr1;
      w[`PIPE_SR2_HI:`PIPE_SR2_LO]   = sr2;
      w[`PIPE_IMM_FLAG]              = use_imm;
      w[`PIPE_IMM_HI:`PIPE_IMM_LO]   = imm;
      return w;
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic set_row(input int i, input logic v, input instr_t w, input logic [2:0] dr,
                          input word_t data, input flags_t f);
      tbl_valid[i] = v;
      tbl_ir[i]    = w;
      tbl_dr[i]    = dr;
      tbl_data[i]  = data;
      tbl_flags[i] = f;
   endtask

   // Runs one instruction through the model and returns what writeback should show
   task automatic model_issue(input instr_t w, output logic [2:0] dr, output word_t data,
                              output flags_t f);
      int          width;
      logic [2:0]  op;
      word_t       mask;
      word_t       a;
      word_t       b;
      word_t       res;
      logic [63:0] wide;
      logic        c;
      op    = w[`PIPE_OP_HI:`PIPE_OP_LO];
      dr    = w[`PIPE_DR_HI:`PIPE_DR_LO];
      case (w[`PIPE_SIZE_HI:`PIPE_SIZE_LO])
         2'd0: width = 8;
         2'd1: width = 16;
         default: width = 32;
      endcase
      mask = (width == 32) ? 32'hffff_ffff : ((32'h1 << width) - 32'h1);
      a = model_regs[w[`PIPE_SR1_HI:`PIPE_SR1_LO]] & mask;
      if (w[`PIPE_IMM_FLAG]) begin
         b = {{16{w[15]}}, w[15:0]} & mask;
      end else begin
         b = model_regs[w[`PIPE_SR2_HI:`PIPE_SR2_LO]] & mask;
      end
      c    = 1'b0;
      wide = '0;
      case (op)
         3'd0: begin
            wide = {32'h0, a} + {32'h0, b};
            c    = wide[width];
         end
         3'd1: begin
            wide = {32'h0, a - b};
            c    = b > a;
         end
         3'd2: wide = {32'h0, a & b};
         3'd3: wide = {32'h0, a | b};
         3'd4: wide = {32'h0, a ^ b};
         3'd5: wide = {32'h0, b};
         3'd6: wide = {32'h0, ~a};
         default: begin
            wide = {32'h0, a} << b[4:0];
            c    = wide[width];
         end
      endcase
      res  = wide[31:0] & mask;
      data = (model_regs[dr] & ~mask) | res;
      model_regs[dr] = data;
      if (op != 3'd5) begin
         model_flags = {res == 32'h0, res[width-1], c};
      end
      f = model_flags;
   endtask

   task automatic drive(input logic v, input instr_t w);
      @(posedge clk);
      #5;
      ir_valid = v;
      ir       = w;
   endtask

   // Writeback checked on the falling edge
   always @(negedge clk) begin
      if (rst_n && wb_valid) begin
         wb_count++;
         assert (exp_dr_q.size() > 0) else begin
            $display("Writeback pulse at %0t with no instruction outstanding", $time);
            errors++;
         end
         if (exp_dr_q.size() > 0) begin
            assert (wb_dr === exp_dr_q[0]) else begin
               $display("FAIL %0t wb_dr got %0d expected %0d", $time, wb_dr, exp_dr_q[0]);
               errors++;
            end
            assert (wb_data === exp_data_q[0]) else begin
               $display("FAIL %0t wb_data got %h expected %h", $time, wb_data, exp_data_q[0]);
               errors++;
            end
            assert (flags === exp_flags_q[0]) else begin
               $display("FAIL %0t flags got %b expected %b", $time, flags, exp_flags_q[0]);
               errors++;
            end
            void'(exp_dr_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_flags_q.pop_front());
         end
      end
   end

   initial begin
      #(TIMEOUT);
      $display("Timeout, pipeline did not drain in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic [2:0]  m_dr;
      word_t       m_data;
      flags_t      m_flags;
      logic [31:0] r;
      logic [31:0] fields;
      int          drain;
      clk = 1'b0;
      rst_n = 1'b0;
      ir_valid = 1'b0;
      ir = '0;
      errors = 0;
      sent_count = 0;
      wb_count = 0;
      lfsr = 32'h67e;
      model_flags = '0;
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end

      // Immediate loads, then arithmetic, shifts, merge and forwarding
      set_row(0,  1, encode(op_mov, 2'd0, 1, 0, 0, 1, 16'h0085), 1, 32'h0000_0085, 3'b000);
      set_row(1,  1, encode(op_mov, 2'd1, 2, 0, 0, 1, 16'h8001), 2, 32'h0000_8001, 3'b000);
      set_row(2,  1, encode(op_mov, 2'd2, 3, 0, 0, 1, 16'h7fff), 3, 32'h0000_7fff, 3'b000);
      set_row(3,  1, encode(op_add, 2'd0, 4, 1, 0, 1, 16'h0080), 4, 32'h0000_0005, 3'b001);
      set_row(4,  1, encode(op_add, 2'd0, 5, 4, 0, 1, 16'h00fb), 5, 32'h0000_0000, 3'b101);
      set_row(5,  1, encode(op_sub, 2'd1, 6, 2, 0, 1, 16'h0001), 6, 32'h0000_8000, 3'b010);
      set_row(6,  1, encode(op_sub, 2'd1, 6, 6, 2, 0, 16'h0000), 6, 32'h0000_ffff, 3'b011);
      set_row(7,  1, encode(op_sub, 2'd2, 7, 3, 3, 0, 16'h0000), 7, 32'h0000_0000, 3'b100);
      set_row(8,  1, encode(op_shl, 2'd0, 1, 1, 0, 1, 16'h0001), 1, 32'h0000_000a, 3'b001);
      set_row(9,  1, encode(op_shl, 2'd1, 2, 2, 0, 1, 16'h0001), 2, 32'h0000_0002, 3'b001);
      set_row(10, 1, encode(op_shl, 2'd2, 3, 3, 0, 1, 16'h0011), 3, 32'hfffe_0000, 3'b010);
      set_row(11, 1, encode(op_xor, 2'd0, 3, 3, 0, 1, 16'h00ff), 3, 32'hfffe_00ff, 3'b010);
      set_row(12, 0, '0, 0, '0, '0);
      set_row(13, 1, encode(op_add, 2'd2, 4, 3, 6, 0, 16'h0000), 4, 32'hffff_00fe, 3'b010);
      set_row(14, 1, encode(op_add, 2'd1, 4, 4, 0, 1, 16'h0102), 4, 32'hffff_0200, 3'b000);
      set_row(15, 1, encode(op_mov, 2'd2, 5, 0, 4, 0, 16'h0000), 5, 32'hffff_0200, 3'b000);
      set_row(16, 1, encode(op_sub, 2'd0, 4, 1, 0, 1, 16'h000b), 4, 32'hffff_02ff, 3'b011);

      repeat (4) @(posedge clk);
      #5;
      rst_n = 1'b1;

      for (int i = 0; i < N_ROWS; i++) begin
         if (tbl_valid[i]) begin
            // Model tracks the table so the random phase starts from the same state
            model_issue(tbl_ir[i], m_dr, m_data, m_flags);
            exp_dr_q.push_back(tbl_dr[i]);
            exp_data_q.push_back(tbl_data[i]);
            exp_flags_q.push_back(tbl_flags[i]);
            sent_count++;
         end
         drive(tbl_valid[i], tbl_ir[i]);
      end

      for (int i = 0; i < N_RAND; i++) begin
         take_bits(1, r);
         if (r[0]) begin
            take_bits(32, fields);
            fields[16] = 1'b0;
            model_issue(fields, m_dr, m_data, m_flags);
            exp_dr_q.push_back(m_dr);
            exp_data_q.push_back(m_data);
            exp_flags_q.push_back(m_flags);
            sent_count++;
            drive(1'b1, fields);
         end else begin
            drive(1'b0, '0);
         end
      end
      drive(1'b0, '0);

      drain = 0;
      while (exp_dr_q.size() > 0 && drain < 10) begin
         @(posedge clk);
         drain++;
      end
      @(posedge clk);

      assert (exp_dr_q.size() == 0) else begin
         $display("%0d expected results never came out of writeback", exp_dr_q.size());
         errors++;
      end
      assert (wb_count == sent_count) else begin
         $display("Sent %0d instructions but saw %0d writeback pulses", sent_count, wb_count);
         errors++;
      end

      $display("Sent %0d, written back %0d, errors %0d", sent_count, wb_count, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
pipe_pkg.sv
decode_stage.sv
operand_stage.sv
gpr_file.sv
execute_stage.sv
pipeline_top.sv
pipeline_properties.sv
tb_pipeline.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pipeline -f filelist.f

out=$(./obj_dir/Vtb_pipeline)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
else
   exit 1
fi
